/* sonata_consts.svh */
/*
   register map, widths and fixed values of the sonata register block
   pulled in by the package, the RTL modules and the testbench
*/
`ifndef SONATA_CONSTS_SVH
`define SONATA_CONSTS_SVH

// bus and payload widths
`define SONATA_DATA_BITS            8
`define SONATA_BLOCK_BITS           128
`define SONATA_BYTECNT_BITS         7

////////////////////
// register addresses
`define SONATA_REG_USER_LED         8'h01
`define SONATA_REG_CRYPT_TYPE       8'h02
`define SONATA_REG_CRYPT_REV        8'h03
`define SONATA_REG_IDENTIFY         8'h04
`define SONATA_REG_CRYPT_GO         8'h05   // write starts the core, read gives busy
`define SONATA_REG_CRYPT_TEXTIN     8'h06
`define SONATA_REG_CRYPT_CIPHERIN   8'h07
`define SONATA_REG_CRYPT_TEXTOUT    8'h08
`define SONATA_REG_CRYPT_CIPHEROUT  8'h09
`define SONATA_REG_CRYPT_KEY        8'h0a
`define SONATA_REG_AES_ALWAYS_ON    8'h0c

// identification bytes
`define SONATA_CRYPT_TYPE           8'd2
`define SONATA_CRYPT_REV            8'd4
`define SONATA_IDENTIFY             8'h2e

// control bits after reset
`define SONATA_USER_LED_RST         1'b0
`define SONATA_ALWAYS_ON_RST        1'b0

// set to 1 for a rising edge done and 0 for a level done
`define SONATA_DONE_EDGE            1

`endif

/* sonata_pkg.sv */
/*
   shared data types of the sonata register block
   imported by every module that moves bytes or blocks around
*/
`default_nettype none

`include "sonata_consts.svh"

package sonata_pkg;

   // one host bus byte, data or address
   typedef logic [`SONATA_DATA_BITS-1:0]    byte_t;

   // byte position inside a multi-byte register
   typedef logic [`SONATA_BYTECNT_BITS-1:0] bytecnt_t;

   // key, text or cipher
   typedef logic [`SONATA_BLOCK_BITS-1:0]   block_t;

endpackage

`default_nettype wire

/* cdc_pulse.sv */
/*
   carries a single cycle pulse from usb_clk to crypto_clk
   source pulses need a few usb_clk cycles between them
*/
`default_nettype none

module cdc_pulse (
   input  wire  usb_clk,
   input  wire  crypto_clk,
   input  wire  reset_i,
   input  wire  src_pulse_i,
   output logic dst_pulse_o
);

   logic       src_toggle;     // flips once per source pulse
   logic [1:0] dst_sync;
   logic       dst_toggle_q;   // last synchronised toggle value

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         src_toggle <= 1'b0;
      end else if (src_pulse_i) begin
         src_toggle <= ~src_toggle;
      end
   end

   ////////////////////
   // crypto_clk side

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         dst_sync     <= '0;
         dst_toggle_q <= 1'b0;
      end else begin
         dst_sync     <= {dst_sync[0], src_toggle};
         dst_toggle_q <= dst_sync[1];
      end
   end

   // any change of the toggle is one pulse
   assign dst_pulse_o = dst_sync[1] ^ dst_toggle_q;

endmodule

`default_nettype wire

/* usb_reg_file.sv */
/*
   usb_clk half of the register block
   host writes land here byte by byte, a go write becomes a one cycle pulse,
   busy and the core results are brought into usb_clk, and reads come back
   through a registered mux one cycle after the strobe
*/
`default_nettype none

`include "sonata_consts.svh"

module usb_reg_file
   import sonata_pkg::*;
(
   input  wire           usb_clk,
   input  wire           reset_i,
   input  wire byte_t    reg_address_i,
   input  wire bytecnt_t reg_bytecnt_i,
   input  wire byte_t    write_data_i,
   input  wire           reg_read_i,
   input  wire           reg_write_i,
   input  wire           reg_addrvalid_i,
   output byte_t         read_data_o,
   input  wire block_t   textout_crypt_i,
   input  wire block_t   cipherout_crypt_i,
   input  wire           busy_i,
   output logic          user_led_o,
   output logic          always_on_o,
   output logic          go_pulse_o,
   output block_t        key_o,
   output block_t        textin_o,
   output block_t        cipherin_o
);

   localparam int BLOCK_BYTES = `SONATA_BLOCK_BITS / `SONATA_DATA_BITS;
   localparam int IDX_BITS    = $clog2(BLOCK_BYTES);

   logic                wr_en;
   logic                rd_en;
   logic                byte_ok;        // index lands inside a 16 byte register
   logic [IDX_BITS-1:0] byte_idx;
   logic [2:0]          busy_sync;
   block_t              textout_usb;
   block_t              cipherout_usb;
   byte_t               rd_byte;

   // pick one byte out of a block
   function automatic byte_t block_byte(
      input block_t              blk,
      input logic [IDX_BITS-1:0] idx
   );
      return blk[idx*`SONATA_DATA_BITS +: `SONATA_DATA_BITS];
   endfunction

   assign wr_en    = reg_addrvalid_i & reg_write_i;
   assign rd_en    = reg_addrvalid_i & reg_read_i;
   assign byte_ok  = (reg_bytecnt_i < BLOCK_BYTES);
   assign byte_idx = reg_bytecnt_i[IDX_BITS-1:0];

   ////////////////////
   // host writes

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         user_led_o  <= `SONATA_USER_LED_RST;
         always_on_o <= `SONATA_ALWAYS_ON_RST;
         key_o       <= '0;
         textin_o    <= '0;
         cipherin_o  <= '0;
      end else if (wr_en) begin
         case (reg_address_i)
            `SONATA_REG_USER_LED:       user_led_o  <= write_data_i[0];
            `SONATA_REG_AES_ALWAYS_ON:  always_on_o <= write_data_i[0];
            `SONATA_REG_CRYPT_KEY: begin
               if (byte_ok)
                  key_o[byte_idx*`SONATA_DATA_BITS +: `SONATA_DATA_BITS] <= write_data_i;
            end
            `SONATA_REG_CRYPT_TEXTIN: begin
               if (byte_ok)
                  textin_o[byte_idx*`SONATA_DATA_BITS +: `SONATA_DATA_BITS] <= write_data_i;
            end
            `SONATA_REG_CRYPT_CIPHERIN: begin
               if (byte_ok)
                  cipherin_o[byte_idx*`SONATA_DATA_BITS +: `SONATA_DATA_BITS] <= write_data_i;
            end
            default: ;                       // read-only or unmapped
         endcase
      end
   end

   // go register holds no data, a write just fires the pulse
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         go_pulse_o <= 1'b0;
      end else begin
         go_pulse_o <= wr_en && (reg_address_i == `SONATA_REG_CRYPT_GO);
      end
   end

   ////////////////////
   // crypto side status and results

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         busy_sync <= '0;
      end else begin
         busy_sync <= {busy_sync[1:0], busy_i};   // busy bit is busy_sync[2]
      end
   end

   // results only move after done, so one stage is enough
   always_ff @(posedge usb_clk) begin
      textout_usb   <= textout_crypt_i;
      cipherout_usb <= cipherout_crypt_i;
   end

   ////////////////////
   // host reads

   always_comb begin
      rd_byte = '0;
      if (rd_en) begin
         case (reg_address_i)
            `SONATA_REG_USER_LED:       rd_byte = byte_t'(user_led_o);
            `SONATA_REG_AES_ALWAYS_ON:  rd_byte = byte_t'(always_on_o);
            `SONATA_REG_CRYPT_TYPE:     rd_byte = `SONATA_CRYPT_TYPE;
            `SONATA_REG_CRYPT_REV:      rd_byte = `SONATA_CRYPT_REV;
            `SONATA_REG_IDENTIFY:       rd_byte = `SONATA_IDENTIFY;
            `SONATA_REG_CRYPT_GO:       rd_byte = byte_t'(busy_sync[2]);
            `SONATA_REG_CRYPT_KEY:
               rd_byte = byte_ok ? block_byte(key_o, byte_idx) : '0;
            `SONATA_REG_CRYPT_TEXTIN:
               rd_byte = byte_ok ? block_byte(textin_o, byte_idx) : '0;
            `SONATA_REG_CRYPT_CIPHERIN:
               rd_byte = byte_ok ? block_byte(cipherin_o, byte_idx) : '0;
            `SONATA_REG_CRYPT_TEXTOUT:
               rd_byte = byte_ok ? block_byte(textout_usb, byte_idx) : '0;
            `SONATA_REG_CRYPT_CIPHEROUT:
               rd_byte = byte_ok ? block_byte(cipherout_usb, byte_idx) : '0;
            default:                    rd_byte = '0;
         endcase
      end
   end

   // data shows up the cycle after the read strobe
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         read_data_o <= '0;
      end else begin
         read_data_o <= rd_byte;
      end
   end

endmodule

`default_nettype wire

/* crypto_handoff.sv */
/*
   crypto_clk half of the register block
   retimes key and text for the core, catches the results on done
   and drives start from either the go pulse or the always-on loop
*/
`default_nettype none

`include "sonata_consts.svh"

module crypto_handoff
   import sonata_pkg::*;
(
   input  wire         crypto_clk,
   input  wire         reset_i,
   input  wire block_t key_i,
   input  wire block_t textin_i,
   input  wire         start_req_i,
   input  wire         always_on_i,
   input  wire         done_i,
   input  wire         busy_i,
   input  wire block_t textout_i,
   input  wire block_t cipherout_i,
   output block_t      key_o,
   output block_t      textin_o,
   output logic        start_o,
   output block_t      textout_o,
   output block_t      cipherout_o
);

   localparam bit DONE_EDGE = `SONATA_DONE_EDGE;

   logic done_q;          // done seen last cycle, stuck at 0 in level mode
   logic done_pulse;
   logic always_on_q;
   logic always_go;

   ////////////////////
   // key and text into crypto_clk

   // host only writes these while the core is idle
   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         key_o    <= '0;
         textin_o <= '0;
      end else begin
         key_o    <= key_i;
         textin_o <= textin_i;
      end
   end

   ////////////////////
   // done detect and result capture

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= done_i & DONE_EDGE;
      end
   end

   assign done_pulse = done_i & ~done_q;

   always_ff @(posedge crypto_clk) begin
      if (done_pulse) begin
         textout_o   <= textout_i;
         cipherout_o <= cipherout_i;
      end
   end

   ////////////////////
   // start source

   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         always_on_q <= 1'b0;
      end else begin
         always_on_q <= always_on_i;            // slow mode bit from usb_clk
      end
   end

   // free-running restart, one high cycle then one low, held off by busy
   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         always_go <= 1'b0;
      end else if (!always_on_q || always_go) begin
         always_go <= 1'b0;
      end else if (!busy_i) begin
         always_go <= 1'b1;
      end
   end

   assign start_o = always_on_q ? always_go : start_req_i;

endmodule

`default_nettype wire

/* sonata_reg_top.sv */
/*
   host register block of the crypto target
   byte bus on usb_clk in, crypto core hooks on crypto_clk out
   the go pulse crosses through cdc_pulse, data through crypto_handoff
*/
`default_nettype none

module sonata_reg_top
   import sonata_pkg::*;
(
   input  wire           usb_clk,
   input  wire           crypto_clk,
   input  wire           reset_i,

   // host register bus
   input  wire byte_t    reg_address_i,
   input  wire bytecnt_t reg_bytecnt_i,
   input  wire byte_t    write_data_i,
   input  wire           reg_read_i,
   input  wire           reg_write_i,
   input  wire           reg_addrvalid_i,
   output byte_t         read_data_o,
   output logic          user_led_o,

   // crypto core
   output block_t        key_o,
   output block_t        textin_o,
   output block_t        cipherin_o,
   output logic          start_o,
   input  wire block_t   textout_i,
   input  wire block_t   cipherout_i,
   input  wire           done_i,
   input  wire           busy_i
);

   logic   go_pulse;           // usb_clk, one cycle per go write
   logic   start_req_crypt;    // same pulse on crypto_clk
   logic   always_on;
   block_t key_usb;
   block_t textin_usb;
   block_t textout_crypt;
   block_t cipherout_crypt;

   usb_reg_file u_reg_file (
      .usb_clk           (usb_clk),
      .reset_i           (reset_i),
      .reg_address_i     (reg_address_i),
      .reg_bytecnt_i     (reg_bytecnt_i),
      .write_data_i      (write_data_i),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .reg_addrvalid_i   (reg_addrvalid_i),
      .read_data_o       (read_data_o),
      .textout_crypt_i   (textout_crypt),
      .cipherout_crypt_i (cipherout_crypt),
      .busy_i            (busy_i),
      .user_led_o        (user_led_o),
      .always_on_o       (always_on),
      .go_pulse_o        (go_pulse),
      .key_o             (key_usb),
      .textin_o          (textin_usb),
      .cipherin_o        (cipherin_o)
   );

   cdc_pulse u_go_cdc (
      .usb_clk           (usb_clk),
      .crypto_clk        (crypto_clk),
      .reset_i           (reset_i),
      .src_pulse_i       (go_pulse),
      .dst_pulse_o       (start_req_crypt)
   );

   crypto_handoff u_handoff (
      .crypto_clk        (crypto_clk),
      .reset_i           (reset_i),
      .key_i             (key_usb),
      .textin_i          (textin_usb),
      .start_req_i       (start_req_crypt),
      .always_on_i       (always_on),
      .done_i            (done_i),
      .busy_i            (busy_i),
      .textout_i         (textout_i),
      .cipherout_i       (cipherout_i),
      .key_o             (key_o),
      .textin_o          (textin_o),
      .start_o           (start_o),
      .textout_o         (textout_crypt),
      .cipherout_o       (cipherout_crypt)
   );

endmodule

`default_nettype wire

/* sonata_checker.sv */
/*
   testbench monitor for the sonata register block
   keeps shadow registers from the host writes and checks every read
   also counts start and done pulses on the core side
*/
`default_nettype none

`include "sonata_consts.svh"

module sonata_checker
   import sonata_pkg::*;
(
   input  wire           usb_clk,
   input  wire           crypto_clk,
   input  wire           reset_i,
   input  wire byte_t    reg_address_i,
   input  wire bytecnt_t reg_bytecnt_i,
   input  wire byte_t    write_data_i,
   input  wire           reg_read_i,
   input  wire           reg_write_i,
   input  wire           reg_addrvalid_i,
   input  wire byte_t    read_data_i,
   input  wire           start_i,
   input  wire           done_i,
   output int            err_count_o,
   output int            start_count_o,
   output int            done_count_o
);

   string    test_name = "none";
   int       err_count = 0;
   int       start_count = 0;
   int       done_count = 0;
   logic     done_q = 1'b0;
   logic     led_sh, on_sh;
   block_t   key_sh, text_sh, cin_sh, tout_sh, cout_sh;
   bit       res_ok;           // results known once a go was written
   bit       pend;             // read waiting for its data
   byte_t    pend_exp, pend_addr;
   bytecnt_t pend_idx;

   // expected read byte from the register map rules
   function automatic byte_t expected_read(input byte_t addr, input bytecnt_t idx);
      block_t blk;
      case (addr)
         `SONATA_REG_USER_LED:        return byte_t'(led_sh);
         `SONATA_REG_AES_ALWAYS_ON:   return byte_t'(on_sh);
         `SONATA_REG_CRYPT_TYPE:      return `SONATA_CRYPT_TYPE;
         `SONATA_REG_CRYPT_REV:       return `SONATA_CRYPT_REV;
         `SONATA_REG_IDENTIFY:        return `SONATA_IDENTIFY;
         `SONATA_REG_CRYPT_KEY:       blk = key_sh;
         `SONATA_REG_CRYPT_TEXTIN:    blk = text_sh;
         `SONATA_REG_CRYPT_CIPHERIN:  blk = cin_sh;
         `SONATA_REG_CRYPT_TEXTOUT:   blk = tout_sh;
         `SONATA_REG_CRYPT_CIPHEROUT: blk = cout_sh;
         default:                     return 8'h00;
      endcase
      if (idx >= 16)
         return 8'h00;                // past the end of a block
      return blk[idx*8 +: 8];
   endfunction

   // busy has no shadow, results none before the first go
   function automatic bit read_checked(input byte_t addr);
      if (addr == `SONATA_REG_CRYPT_GO)
         return 1'b0;
      if (addr == `SONATA_REG_CRYPT_TEXTOUT || addr == `SONATA_REG_CRYPT_CIPHEROUT)
         return res_ok;
      return 1'b1;
   endfunction

   task automatic check_value(input string name, input block_t exp, input block_t act);
      if (act !== exp) begin
         err_count++;
         $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic set_test(input string name);
      test_name = name;
   endtask

   ////////////////////
   // host side shadow and read compare

   always @(posedge usb_clk) begin
      if (reset_i) begin
         {led_sh, on_sh} = {`SONATA_USER_LED_RST, `SONATA_ALWAYS_ON_RST};
         {key_sh, text_sh, cin_sh} = '0;
         res_ok = 1'b0;
         pend   = 1'b0;
      end else begin
         if (pend)
            check_value($sformatf("%s read %h[%0d]", test_name, pend_addr, pend_idx),
                        pend_exp, read_data_i);
         pend = reg_addrvalid_i && reg_read_i && read_checked(reg_address_i);
         pend_exp  = expected_read(reg_address_i, reg_bytecnt_i);
         pend_addr = reg_address_i;
         pend_idx  = reg_bytecnt_i;
         if (reg_addrvalid_i && reg_write_i) begin
            case (reg_address_i)
               `SONATA_REG_USER_LED:       led_sh = write_data_i[0];
               `SONATA_REG_AES_ALWAYS_ON:  on_sh  = write_data_i[0];
               `SONATA_REG_CRYPT_KEY:      if (reg_bytecnt_i < 16) key_sh[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_CRYPT_TEXTIN:   if (reg_bytecnt_i < 16) text_sh[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_CRYPT_CIPHERIN: if (reg_bytecnt_i < 16) cin_sh[reg_bytecnt_i*8 +: 8] = write_data_i;
               `SONATA_REG_CRYPT_GO: begin
                  tout_sh = text_sh;             // core echoes the text
                  cout_sh = text_sh ^ key_sh;
                  res_ok  = 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // core side pulse counts
   always @(posedge crypto_clk) begin
      if (!reset_i) begin
         if (start_i === 1'b1) start_count++;
         if (done_i === 1'b1 && !done_q) done_count++;
      end
      done_q = (done_i === 1'b1);
   end

   assign err_count_o   = err_count;
   assign start_count_o = start_count;
   assign done_count_o  = done_count;

endmodule

`default_nettype wire

/* tb_sonata_reg.sv */
/*
   testbench for the sonata register block
   drives the host bus, plays a small crypto core and lets sonata_checker compare
*/
`default_nettype none

`include "sonata_consts.svh"

module tb_sonata_reg
   import sonata_pkg::*;
();

   logic     usb_clk = 1'b0;
   logic     crypto_clk = 1'b0;
   logic     reset;
   byte_t    reg_address, write_data, read_data, rd;
   bytecnt_t reg_bytecnt;
   logic     reg_read, reg_write, reg_addrvalid, user_led, start, done, busy;
   block_t   key, textin, cipherin, textout, cipherout;
   block_t   exp_key, exp_text, exp_cin;
   logic [31:0] lfsr = 32'h0172_4da4;
   int       errors, starts, dones, n, n0;
   int       timeouts = 0;

   initial forever #4 usb_clk = ~usb_clk;
   initial forever #5 crypto_clk = ~crypto_clk;

   sonata_reg_top u_dut (
      .usb_clk(usb_clk), .crypto_clk(crypto_clk), .reset_i(reset),
      .reg_address_i(reg_address), .reg_bytecnt_i(reg_bytecnt), .write_data_i(write_data),
      .reg_read_i(reg_read), .reg_write_i(reg_write), .reg_addrvalid_i(reg_addrvalid),
      .read_data_o(read_data), .user_led_o(user_led), .key_o(key), .textin_o(textin),
      .cipherin_o(cipherin), .start_o(start), .textout_i(textout), .cipherout_i(cipherout),
      .done_i(done), .busy_i(busy)
   );

   sonata_checker u_chk (
      .usb_clk(usb_clk), .crypto_clk(crypto_clk), .reset_i(reset),
      .reg_address_i(reg_address), .reg_bytecnt_i(reg_bytecnt), .write_data_i(write_data),
      .reg_read_i(reg_read), .reg_write_i(reg_write), .reg_addrvalid_i(reg_addrvalid),
      .read_data_i(read_data), .start_i(start), .done_i(done),
      .err_count_o(errors), .start_count_o(starts), .done_count_o(dones)
   );

   // stand-in core echoes the text and returns text xor key as cipher
   initial begin
      {busy, done, textout, cipherout} = '0;
      forever begin
         @(posedge crypto_clk);
         if (start === 1'b1 && !reset) begin
            #1;
            busy      = 1'b1;
            textout   = textin;
            cipherout = textin ^ key;
            repeat (12) @(posedge crypto_clk);
            #1 done = 1'b1;
            @(posedge crypto_clk);
            #1;
            done = 1'b0;
            busy = 1'b0;
         end
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_byte(output byte_t b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);             // one step per bit
         b = {b[6:0], lfsr[0]};
      end
   endtask

   task automatic bus_write(input byte_t addr, input bytecnt_t idx, input byte_t data);
      @(posedge usb_clk);
      #1;
      {reg_addrvalid, reg_write} = 2'b11;
      {reg_address, reg_bytecnt, write_data} = {addr, idx, data};
      @(posedge usb_clk);
      #1;
      {reg_addrvalid, reg_write} = 2'b00;
   endtask

   task automatic bus_read(input byte_t addr, input bytecnt_t idx, output byte_t data);
      @(posedge usb_clk);
      #1;
      {reg_addrvalid, reg_read, reg_address, reg_bytecnt} = {2'b11, addr, idx};
      @(posedge usb_clk);
      #1;
      {reg_addrvalid, reg_read} = 2'b00;
      data = read_data;                      // registered one cycle after the strobe
   endtask

   task automatic read_block(input byte_t addr);
      byte_t data;
      for (int i = 0; i < 16; i++) bus_read(addr, bytecnt_t'(i), data);
   endtask

   task automatic write_block(input byte_t addr, output block_t blk);
      byte_t b;
      blk = '0;
      for (int i = 0; i < 16; i++) begin
         rand_byte(b);
         blk[i*8 +: 8] = b;
         bus_write(addr, bytecnt_t'(i), b);
      end
   endtask

   task automatic wait_busy(input logic level);
      byte_t data;
      int    tries;
      bus_read(`SONATA_REG_CRYPT_GO, 0, data);
      tries = 1;
      while (data[0] !== level && tries < 100) begin
         bus_read(`SONATA_REG_CRYPT_GO, 0, data);
         tries++;
      end
      if (data[0] !== level) begin
         timeouts++;
         $display("Timeout: busy bit never read %0d", level);
      end
   endtask

   initial begin
      reset = 1'b1;
      {reg_address, reg_bytecnt, write_data, reg_read, reg_write, reg_addrvalid} = '0;
      repeat (3) @(posedge usb_clk);
      #1 reset = 1'b0;

      u_chk.set_test("reset_values");
      bus_read(`SONATA_REG_USER_LED, 0, rd);
      bus_read(`SONATA_REG_AES_ALWAYS_ON, 0, rd);
      bus_read(`SONATA_REG_CRYPT_TYPE, 0, rd);
      bus_read(`SONATA_REG_CRYPT_REV, 0, rd);
      bus_read(`SONATA_REG_IDENTIFY, 0, rd);
      bus_read(8'h00, 0, rd);
      bus_read(8'h3f, 0, rd);
      read_block(`SONATA_REG_CRYPT_KEY);
      bus_read(`SONATA_REG_CRYPT_GO, 0, rd);
      u_chk.check_value("reset_values busy", '0, block_t'(rd));
      u_chk.check_value("reset_values user_led", '0, block_t'(user_led));

      u_chk.set_test("readback");
      write_block(`SONATA_REG_CRYPT_KEY, exp_key);
      write_block(`SONATA_REG_CRYPT_TEXTIN, exp_text);
      write_block(`SONATA_REG_CRYPT_CIPHERIN, exp_cin);
      bus_write(`SONATA_REG_USER_LED, 0, 8'h01);
      read_block(`SONATA_REG_CRYPT_KEY);
      read_block(`SONATA_REG_CRYPT_TEXTIN);
      read_block(`SONATA_REG_CRYPT_CIPHERIN);
      bus_read(`SONATA_REG_CRYPT_KEY, 20, rd);      // past the last key byte
      bus_read(`SONATA_REG_USER_LED, 0, rd);
      u_chk.check_value("readback user_led", block_t'(1), block_t'(user_led));
      n = 0;
      while ((key !== exp_key || textin !== exp_text || cipherin !== exp_cin) && n < 100) begin
         @(posedge usb_clk);
         n++;
      end
      if (n >= 100) begin
         timeouts++;
         $display("Timeout: core inputs never matched the written registers");
      end
      u_chk.check_value("core key", exp_key, key);
      u_chk.check_value("core textin", exp_text, textin);
      u_chk.check_value("core cipherin", exp_cin, cipherin);

      for (int blk = 0; blk < 3; blk++) begin
         u_chk.set_test($sformatf("encrypt %0d", blk));
         if (blk > 0) begin
            write_block(`SONATA_REG_CRYPT_KEY, exp_key);
            write_block(`SONATA_REG_CRYPT_TEXTIN, exp_text);
         end
         n0 = starts;
         bus_write(`SONATA_REG_CRYPT_GO, 0, 8'h01);
         wait_busy(1'b1);
         wait_busy(1'b0);
         u_chk.check_value("go start pulses", block_t'(n0 + 1), block_t'(starts));
         read_block(`SONATA_REG_CRYPT_TEXTOUT);
         read_block(`SONATA_REG_CRYPT_CIPHEROUT);
      end

      u_chk.set_test("always_on");
      bus_write(`SONATA_REG_AES_ALWAYS_ON, 0, 8'h01);
      bus_read(`SONATA_REG_AES_ALWAYS_ON, 0, rd);
      n0 = dones;
      n  = 0;
      while (dones < n0 + 4 && n < 1000) begin
         @(posedge usb_clk);
         n++;
      end
      if (n >= 1000) begin
         timeouts++;
         $display("Timeout: always-on mode did not restart the core 4 times");
      end
      bus_write(`SONATA_REG_AES_ALWAYS_ON, 0, 8'h00);
      repeat (3) @(posedge crypto_clk);      // mode bit reaches crypto_clk
      n = 0;
      while (busy && n < 100) begin
         @(posedge crypto_clk);
         n++;
      end
      if (n >= 100) begin
         timeouts++;
         $display("Timeout: core stayed busy after always-on was cleared");
      end
      n0 = starts;
      repeat (50) @(posedge crypto_clk);
      u_chk.check_value("always_on cleared starts", block_t'(n0), block_t'(starts));

      $display("value errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* sonata_reg_top.f */
+incdir+.
sonata_pkg.sv
cdc_pulse.sv
usb_reg_file.sv
crypto_handoff.sv
sonata_reg_top.sv
sonata_checker.sv
tb_sonata_reg.sv
